/* Makefile */
VERILATOR ?= verilator
TOP       ?= drumMeshTb
FILELIST  ?= all.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "test failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* all.f */
+incdir+include
logic/drumPkg.sv
logic/meshPkg.sv
logic/stepCtrlIf.sv
logic/fixedMul.sv
logic/meshSequencer.sv
logic/compNode.sv
logic/meshReadout.sv
logic/drumMesh.sv
test/drumMesh_sva.sv
test/drumMeshTb.sv

/* logic/compNode.sv */
`timescale 1ns/1ps

module compNode #(
  parameter int xID = 0,
  parameter int yID = 0
) (
  input  logic             clk,
  input  logic             reset,
  input  drumPkg::fixed18  uNorth,
  input  drumPkg::fixed18  uSouth,
  input  drumPkg::fixed18  uEast,
  input  drumPkg::fixed18  uWest,
  stepCtrlIf.node          ctrl,
  output drumPkg::fixed18  u
);

  drumPkg::fixed18 uPrev;

  // Coupling product kept for the damping multiply
  drumPkg::fixed18 coupleProd;

  // Product of the previous phase
  drumPkg::fixed18 prod;

  drumPkg::fixed18 multA;
  drumPkg::fixed18 multB;
  drumPkg::fixed18 multOut;
  drumPkg::fixed18 laplace;
  drumPkg::fixed18 dampSum;
  logic            strikeHit;

  // Discrete Laplacian, wraps at 18 bits
  assign laplace = uNorth + uSouth + uEast + uWest - (u <<< 2);

  // In mulDamp prod still holds the history product
  assign dampSum = coupleProd + (u <<< 1) - prod;

  assign strikeHit = (ctrl.strikeX == meshPkg::coordT'(xID)) &&
                     (ctrl.strikeY == meshPkg::coordT'(yID));

  // Operand select for the shared multiplier
  always_comb
  begin
    multA = '0;
    multB = '0;
    case (ctrl.phase)
      meshPkg::mulCouple:
      begin
        multA = ctrl.rhoCoef;
        multB = laplace;
      end
      meshPkg::mulHistory:
      begin
        multA = ctrl.dampCoef;
        multB = uPrev;
      end
      meshPkg::mulDamp:
      begin
        multA = ctrl.dampCoef;
        multB = dampSum;
      end
      default:
      begin
        multA = '0;
        multB = '0;
      end
    endcase
  end

  fixedMul mult (
    .a       (multA),
    .b       (multB),
    .product (multOut)
  );

  always_ff @(posedge clk)
  begin
    if (ctrl.phase == meshPkg::mulCouple ||
        ctrl.phase == meshPkg::mulHistory ||
        ctrl.phase == meshPkg::mulDamp)
      prod <= multOut;
    if (ctrl.phase == meshPkg::mulHistory)
      coupleProd <= prod;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      u     <= '0;
      uPrev <= '0;
    end
    else if (ctrl.strike)
    begin
      // Only the struck node starts displaced
      u     <= strikeHit ? ctrl.strikeAmp : '0;
      uPrev <= '0;
    end
    else if (ctrl.phase == meshPkg::update)
    begin
      u     <= prod;
      uPrev <= u;
    end
  end

endmodule

/* logic/drumMesh.sv */
`timescale 1ns/1ps

module drumMesh (
  input  logic             clk,
  input  logic             reset,
  input  logic             run,
  input  logic             strike,
  input  meshPkg::coordT   strikeX,
  input  meshPkg::coordT   strikeY,
  input  drumPkg::fixed18  strikeAmp,
  input  logic [2:0]       tensionSel,
  input  drumPkg::fixed18  eta,
  input  meshPkg::coordT   probeX,
  input  meshPkg::coordT   probeY,
  output drumPkg::fixed18  sample,
  output logic             sampleValid
);

  stepCtrlIf ctrl ();

  // Every node output lands in its slot of the field
  wire meshPkg::meshField field;

  meshSequencer sequencer (
    .clk        (clk),
    .reset      (reset),
    .run        (run),
    .strike     (strike),
    .strikeX    (strikeX),
    .strikeY    (strikeY),
    .strikeAmp  (strikeAmp),
    .tensionSel (tensionSel),
    .eta        (eta),
    .ctrl       (ctrl.sequencer)
  );

  genvar gx, gy;
  for (gy = 0; gy < meshPkg::meshSize; gy++)
  begin : row
    for (gx = 0; gx < meshPkg::meshSize; gx++)
    begin : col
      wire drumPkg::fixed18 nNorth;
      wire drumPkg::fixed18 nSouth;
      wire drumPkg::fixed18 nEast;
      wire drumPkg::fixed18 nWest;

      // Clamped rim reads as zero
      if (gy > 0) assign nNorth = field[(gy - 1) * meshPkg::meshSize + gx];
      else assign nNorth = '0;
      if (gy < meshPkg::meshSize - 1) assign nSouth = field[(gy + 1) * meshPkg::meshSize + gx];
      else assign nSouth = '0;
      if (gx > 0) assign nWest = field[gy * meshPkg::meshSize + gx - 1];
      else assign nWest = '0;
      if (gx < meshPkg::meshSize - 1) assign nEast = field[gy * meshPkg::meshSize + gx + 1];
      else assign nEast = '0;

      compNode #(
        .xID (gx),
        .yID (gy)
      ) node (
        .clk    (clk),
        .reset  (reset),
        .uNorth (nNorth),
        .uSouth (nSouth),
        .uEast  (nEast),
        .uWest  (nWest),
        .ctrl   (ctrl.node),
        .u      (field[gy * meshPkg::meshSize + gx])
      );
    end
  end

  meshReadout readout (
    .clk         (clk),
    .reset       (reset),
    .field       (field),
    .probeX      (probeX),
    .probeY      (probeY),
    .ctrl        (ctrl.observer),
    .sample      (sample),
    .sampleValid (sampleValid)
  );

endmodule

/* logic/drumPkg.sv */
package drumPkg;

  // Width of every datapath word
  localparam int fixedBits = 18;

  // Binary point position
  localparam int fracBits = 16;

  // Signed Q2.16 word
  typedef logic signed [fixedBits-1:0] fixed18;

  localparam fixed18 fixedOne = 18'sh1_0000;

  // Saturation limits
  localparam fixed18 fixedMax = 18'sh1_FFFF;
  localparam fixed18 fixedMin = 18'sh2_0000;

  // Coupling coefficient rho per tension select
  // Steps of 1/16 with the top entry jumping to one half
  localparam fixed18 rhoTable [8] = '{
    18'sh0_0000,
    18'sh0_1000,
    18'sh0_2000,
    18'sh0_3000,
    18'sh0_4000,
    18'sh0_5000,
    18'sh0_6000,
    18'sh0_8000
  };

  // Multiply takes the full 36-bit product and shifts it right
  // arithmetically by fracBits, then saturates it into fixed18.
  // Add and subtract simply wrap at 18 bits.

endpackage

/* logic/fixedMul.sv */
`timescale 1ns/1ps

module fixedMul (
  input  drumPkg::fixed18 a,
  input  drumPkg::fixed18 b,
  output drumPkg::fixed18 product
);

  logic signed [35:0] fullProd;
  logic signed [35:0] shifted;

  assign fullProd = a * b;

  // Drop the extra fraction bits of the product
  assign shifted = fullProd >>> drumPkg::fracBits;

  always_comb
  begin
    if (shifted > drumPkg::fixedMax)
      product = drumPkg::fixedMax;
    else if (shifted < drumPkg::fixedMin)
      product = drumPkg::fixedMin;
    else
      product = shifted[17:0];
  end

endmodule

/* logic/meshPkg.sv */
package meshPkg;

  // Nodes along one side of the membrane
  localparam int meshSize = 4;

  localparam int nodeCount = meshSize * meshSize;

  // Node coordinate along x or y
  typedef logic [1:0] coordT;

  // One time step walks through the three multiplies and the update
  typedef enum logic [2:0] {
    idle,
    mulCouple,
    mulHistory,
    mulDamp,
    update
  } stepPhase;

  // Whole displacement field
  // Row major, node (x, y) sits at index y * meshSize + x
  typedef drumPkg::fixed18 [nodeCount-1:0] meshField;

endpackage

/* logic/meshReadout.sv */
`timescale 1ns/1ps

module meshReadout (
  input  logic              clk,
  input  logic              reset,
  input  meshPkg::meshField field,
  input  meshPkg::coordT    probeX,
  input  meshPkg::coordT    probeY,
  stepCtrlIf.observer       ctrl,
  output drumPkg::fixed18   sample,
  output logic              sampleValid
);

  int   probeIdx;

  // Set by update, the field shows the new values one cycle later
  logic pending;

  always_comb
  begin
    probeIdx = int'(probeY) * meshPkg::meshSize + int'(probeX);
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      pending     <= 1'b0;
      sampleValid <= 1'b0;
      sample      <= '0;
    end
    else if (ctrl.strike)
    begin
      // Drop any sample of the field being replaced
      pending     <= 1'b0;
      sampleValid <= 1'b0;
      sample      <= '0;
    end
    else
    begin
      pending     <= (ctrl.phase == meshPkg::update);
      sampleValid <= pending;
      if (pending)
        sample <= field[probeIdx];
    end
  end

endmodule

/* logic/meshSequencer.sv */
`timescale 1ns/1ps

module meshSequencer (
  input  logic             clk,
  input  logic             reset,
  input  logic             run,
  input  logic             strike,
  input  meshPkg::coordT   strikeX,
  input  meshPkg::coordT   strikeY,
  input  drumPkg::fixed18  strikeAmp,
  input  logic [2:0]       tensionSel,
  input  drumPkg::fixed18  eta,
  stepCtrlIf.sequencer     ctrl
);

  meshPkg::stepPhase nextPhase;
  logic              stepStart;

  always_comb
  begin
    nextPhase = ctrl.phase;
    case (ctrl.phase)
      meshPkg::idle:
        if (run)
          nextPhase = meshPkg::mulCouple;
      meshPkg::mulCouple:
        nextPhase = meshPkg::mulHistory;
      meshPkg::mulHistory:
        nextPhase = meshPkg::mulDamp;
      meshPkg::mulDamp:
        nextPhase = meshPkg::update;
      meshPkg::update:
        // Run only counts at a step boundary
        nextPhase = run ? meshPkg::mulCouple : meshPkg::idle;
      default:
        nextPhase = meshPkg::idle;
    endcase

    // A strike wins over any step in flight
    if (strike)
      nextPhase = meshPkg::idle;
  end

  assign stepStart = (ctrl.phase == meshPkg::idle) && (nextPhase == meshPkg::mulCouple);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ctrl.phase  <= meshPkg::idle;
      ctrl.strike <= 1'b0;
    end
    else
    begin
      ctrl.phase  <= nextPhase;
      ctrl.strike <= strike;
    end
  end

  // Strike operands follow the pulse by one cycle
  always_ff @(posedge clk)
  begin
    if (strike)
    begin
      ctrl.strikeX   <= strikeX;
      ctrl.strikeY   <= strikeY;
      ctrl.strikeAmp <= strikeAmp;
    end
  end

  // Coefficients are frozen when a run starts
  always_ff @(posedge clk)
  begin
    if (stepStart)
    begin
      ctrl.rhoCoef  <= drumPkg::rhoTable[tensionSel];
      ctrl.dampCoef <= drumPkg::fixedOne - eta;
    end
  end

endmodule

/* logic/stepCtrlIf.sv */
`timescale 1ns/1ps

interface stepCtrlIf;

  meshPkg::stepPhase phase;

  // Registered strike and its operands
  logic              strike;
  meshPkg::coordT    strikeX;
  meshPkg::coordT    strikeY;
  drumPkg::fixed18   strikeAmp;

  // Coefficients held for the whole step
  drumPkg::fixed18   rhoCoef;
  // Already one minus eta
  drumPkg::fixed18   dampCoef;

  modport sequencer (output phase, strike, strikeX, strikeY, strikeAmp, rhoCoef, dampCoef);

  modport node (input phase, strike, strikeX, strikeY, strikeAmp, rhoCoef, dampCoef);

  modport observer (input phase, strike);

endinterface

/* include/meshModel.svh */
`ifndef MESH_MODEL_SVH
`define MESH_MODEL_SVH

// Model field, indexed [y][x]
drumPkg::fixed18 modelU    [meshPkg::meshSize][meshPkg::meshSize];
drumPkg::fixed18 modelPrev [meshPkg::meshSize][meshPkg::meshSize];

// Same shift and saturation as the hardware multiplier
function automatic drumPkg::fixed18 modelMul(drumPkg::fixed18 a, drumPkg::fixed18 b);
  logic signed [35:0] fullProd;
  fullProd = a * b;
  fullProd = fullProd >>> drumPkg::fracBits;
  if (fullProd > drumPkg::fixedMax)
    return drumPkg::fixedMax;
  if (fullProd < drumPkg::fixedMin)
    return drumPkg::fixedMin;
  return fullProd[17:0];
endfunction

// Neighbor lookup with the clamped rim
function automatic drumPkg::fixed18 modelAt(int x, int y);
  if (x < 0 || y < 0 || x >= meshPkg::meshSize || y >= meshPkg::meshSize)
    return '0;
  return modelU[y][x];
endfunction

// Sixteenths of one, except the top select which jumps to one half
function automatic drumPkg::fixed18 modelRho(logic [2:0] sel);
  if (sel == 3'd7)
    return 18'sh0_8000;
  return drumPkg::fixed18'(int'(sel) * 'h1000);
endfunction

function automatic drumPkg::fixed18 modelDamp(drumPkg::fixed18 eta);
  return drumPkg::fixedOne - eta;
endfunction

task automatic modelStrike(int sx, int sy, drumPkg::fixed18 amp);
  for (int y = 0; y < meshPkg::meshSize; y++)
    for (int x = 0; x < meshPkg::meshSize; x++)
    begin
      modelU[y][x]    = (x == sx && y == sy) ? amp : '0;
      modelPrev[y][x] = '0;
    end
endtask

// One full time step over the whole grid
task automatic modelStep(drumPkg::fixed18 rho, drumPkg::fixed18 damp);
  drumPkg::fixed18 nextU [meshPkg::meshSize][meshPkg::meshSize];
  drumPkg::fixed18 lap;
  drumPkg::fixed18 couple;
  drumPkg::fixed18 hist;
  drumPkg::fixed18 dampSum;
  for (int y = 0; y < meshPkg::meshSize; y++)
    for (int x = 0; x < meshPkg::meshSize; x++)
    begin
      lap = modelAt(x, y - 1) + modelAt(x, y + 1) + modelAt(x + 1, y) + modelAt(x - 1, y)
            - (modelU[y][x] <<< 2);
      couple  = modelMul(rho, lap);
      hist    = modelMul(damp, modelPrev[y][x]);
      dampSum = couple + (modelU[y][x] <<< 1) - hist;
      nextU[y][x] = modelMul(damp, dampSum);
    end
  modelPrev = modelU;
  modelU    = nextU;
endtask

`endif

/* test/drumMeshTb.sv */
`timescale 1ns/1ps

module drumMeshTb;

  localparam int randTrials = 5;
  // Steps summed over every test
  localparam int totalSteps = 30 + 5 + 8 * 10 + 17 + randTrials * 15;
  localparam int strikeCount = 1 + 5 + 8 + 2 + randTrials;
  // Reset, idle checks, steps, strike overhead, margin
  localparam int limitCycles = 10 + 40 + totalSteps * 4 + strikeCount * 12 + 200;

  localparam drumPkg::fixed18 half = 18'sh0_8000;

  logic            clk;
  logic            reset;
  logic            run;
  logic            strike;
  meshPkg::coordT  strikeX;
  meshPkg::coordT  strikeY;
  drumPkg::fixed18 strikeAmp;
  logic [2:0]      tensionSel;
  drumPkg::fixed18 eta;
  meshPkg::coordT  probeX;
  meshPkg::coordT  probeY;
  drumPkg::fixed18 sample;
  logic            sampleValid;

  int errors;
  int checks;

  // Coefficients of the current model run
  drumPkg::fixed18 curRho;
  drumPkg::fixed18 curDamp;

  `include "meshModel.svh"

  drumMesh uut (
    .clk         (clk),
    .reset       (reset),
    .run         (run),
    .strike      (strike),
    .strikeX     (strikeX),
    .strikeY     (strikeY),
    .strikeAmp   (strikeAmp),
    .tensionSel  (tensionSel),
    .eta         (eta),
    .probeX      (probeX),
    .probeY      (probeY),
    .sample      (sample),
    .sampleValid (sampleValid)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial
  begin
    repeat (limitCycles) @(posedge clk);
    $display("timeout, the tests did not finish within %0d cycles", limitCycles);
    $display("test failed");
    $finish;
  end

  task automatic compareSample(string name, drumPkg::fixed18 got, drumPkg::fixed18 expected);
    checks++;
    if (got !== expected)
    begin
      errors++;
      $display("mismatch %s got %h expected %h", name, got, expected);
    end
  endtask

  task automatic compareStrobe(string name, bit got, bit expected);
    checks++;
    if (got !== expected)
    begin
      errors++;
      $display("mismatch %s got %h expected %h", name, got, expected);
    end
  endtask

  task automatic strikeAt(int x, int y, drumPkg::fixed18 amp, logic [2:0] sel,
                          drumPkg::fixed18 etaVal, int px, int py);
    @(posedge clk);
    strike     <= 1'b1;
    strikeX    <= meshPkg::coordT'(x);
    strikeY    <= meshPkg::coordT'(y);
    strikeAmp  <= amp;
    tensionSel <= sel;
    eta        <= etaVal;
    probeX     <= meshPkg::coordT'(px);
    probeY     <= meshPkg::coordT'(py);
    run        <= 1'b1;
    @(posedge clk);
    strike <= 1'b0;
    // Readout drops a leftover strobe of the old field on this edge
    @(posedge clk);
    modelStrike(x, y, amp);
    curRho  = modelRho(sel);
    curDamp = modelDamp(etaVal);
  endtask

  task automatic waitStrobe();
    int n;
    n = 0;
    @(negedge clk);
    while (sampleValid !== 1'b1 && n < 40)
    begin
      @(negedge clk);
      n++;
    end
    if (sampleValid !== 1'b1)
    begin
      errors++;
      $display("no sample strobe arrived within 40 cycles");
    end
  endtask

  task automatic runSteps(int steps);
    for (int s = 0; s < steps; s++)
    begin
      if (s == 0)
        waitStrobe();
      else
      begin
        // One strobe per four-cycle step
        repeat (3)
        begin
          @(negedge clk);
          compareStrobe("sampleValid", sampleValid, 1'b0);
        end
        @(negedge clk);
        compareStrobe("sampleValid", sampleValid, 1'b1);
      end
      modelStep(curRho, curDamp);
      compareSample("sample", sample, modelU[probeY][probeX]);
    end
  endtask

  task automatic testReset();
    repeat (20)
    begin
      @(negedge clk);
      compareStrobe("sampleValid", sampleValid, 1'b0);
      compareSample("sample", sample, '0);
    end
  endtask

  task automatic testPropagation();
    int nx [4] = '{0, 2, 1, 1};
    int ny [4] = '{1, 1, 0, 2};
    for (int i = 0; i < 4; i++)
    begin
      strikeAt(1, 1, half, 3'd4, '0, nx[i], ny[i]);
      runSteps(1);
      // Quarter coupling of a half amplitude
      compareSample("sample", sample, 18'sh0_2000);
    end
    strikeAt(1, 1, half, 3'd4, '0, 3, 3);
    runSteps(1);
    compareSample("sample", sample, '0);
  endtask

  task automatic testTension();
    for (int sel = 0; sel < 8; sel++)
    begin
      strikeAt(1, 1, half, 3'(sel), 18'sh0_0800, 1, 1);
      runSteps(10);
    end
  endtask

  task automatic testPauseRestrike();
    strikeAt(1, 1, half, 3'd5, 18'sh0_0400, 1, 2);
    runSteps(3);
    @(posedge clk);
    run <= 1'b0;
    // The step in flight still completes
    runSteps(1);
    repeat (20)
    begin
      @(negedge clk);
      compareStrobe("sampleValid", sampleValid, 1'b0);
    end
    @(posedge clk);
    run <= 1'b1;
    runSteps(5);
    repeat (6) @(posedge clk);
    strikeAt(2, 1, 18'sh3_C000, 3'd6, 18'sh0_0400, 2, 1);
    runSteps(8);
  endtask

  task automatic testRandom();
    int x;
    int y;
    drumPkg::fixed18 amp;
    logic [2:0] sel;
    drumPkg::fixed18 etaVal;
    for (int t = 0; t < randTrials; t++)
    begin
      x      = int'($urandom % 4);
      y      = int'($urandom % 4);
      amp    = drumPkg::fixed18'($urandom % 32'h1_0000) - half;
      sel    = 3'($urandom % 8);
      etaVal = drumPkg::fixed18'($urandom % 32'h2000);
      strikeAt(x, y, amp, sel, etaVal, int'($urandom % 4), int'($urandom % 4));
      runSteps(15);
    end
  endtask

  initial
  begin
    void'($urandom(32'h10d4_a9aa));
    errors     = 0;
    checks     = 0;
    reset      = 1'b1;
    run        = 1'b0;
    strike     = 1'b0;
    strikeX    = '0;
    strikeY    = '0;
    strikeAmp  = '0;
    tensionSel = '0;
    eta        = '0;
    probeX     = '0;
    probeY     = '0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    testReset();
    strikeAt(1, 1, half, 3'd4, '0, 1, 1);
    runSteps(30);
    testPropagation();
    testTension();
    testPauseRestrike();
    testRandom();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

endmodule

/* test/drumMesh_sva.sv */
`timescale 1ns/1ps

module drumMeshSva (
  input logic              clk,
  input logic              reset,
  input meshPkg::stepPhase phase,
  input logic              strike,
  input logic              sampleValid
);

  // Strike cuts a step short and parks the mesh in idle
  logic restart;
  assign restart = (phase == meshPkg::idle) && strike;

  coupleOrder: assert property (@(posedge clk) disable iff (reset)
    phase == meshPkg::mulCouple |=> phase == meshPkg::mulHistory || restart)
    else $error("mulCouple not followed by mulHistory");

  historyOrder: assert property (@(posedge clk) disable iff (reset)
    phase == meshPkg::mulHistory |=> phase == meshPkg::mulDamp || restart)
    else $error("mulHistory not followed by mulDamp");

  dampOrder: assert property (@(posedge clk) disable iff (reset)
    phase == meshPkg::mulDamp |=> phase == meshPkg::update || restart)
    else $error("mulDamp not followed by update");

  updateOrder: assert property (@(posedge clk) disable iff (reset)
    phase == meshPkg::update |=> phase == meshPkg::mulCouple || phase == meshPkg::idle)
    else $error("update not followed by mulCouple or idle");

  strobeWidth: assert property (@(posedge clk) disable iff (reset)
    sampleValid |=> !sampleValid)
    else $error("sampleValid longer than one cycle");

  strobeAfterUpdate: assert property (@(posedge clk) disable iff (reset)
    sampleValid |-> $past(phase, 2) == meshPkg::update)
    else $error("sampleValid without a preceding update");

  // Idle after a strike drops the strobe of the replaced field
  quietIdle: assert property (@(posedge clk) disable iff (reset)
    restart |=> !sampleValid)
    else $error("sampleValid while idle after a strike");

endmodule

bind meshReadout drumMeshSva sva (
  .clk         (clk),
  .reset       (reset),
  .phase       (ctrl.phase),
  .strike      (ctrl.strike),
  .sampleValid (sampleValid)
);
